// ==== design/isaPkg.sv ====
package isaPkg;

    // ========================================
    // Widths and opcodes
    // ========================================
    localparam int XLEN = 32;

    // Base opcodes handled by the core
    typedef enum logic [6:0] {
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        I_OP   = 7'b0010011,
        R_OP   = 7'b0110011
    } tOpcode;

    // Branch conditions
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // ALU functions, SRL and SRA share one code
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // funct7 bit that selects SUB and SRA
    localparam int F7_ALT_BIT = 5;

    // ========================================
    // Instruction formats
    // ========================================
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } tInstrR;

    typedef struct packed {
        logic [11:0] imm11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } tInstrI;

    typedef struct packed {
        logic [6:0] imm11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm4_0;
        logic [6:0] opcode;
    } tInstrS;

    // Scrambled branch offset, bit 0 implied zero
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } tInstrB;

    typedef struct packed {
        logic [19:0] imm31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } tInstrU;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } tInstrJ;

    // One fetched word, six views
    typedef union packed {
        tInstrR r;
        tInstrI i;
        tInstrS s;
        tInstrB b;
        tInstrU u;
        tInstrJ j;
    } tInstr;

endpackage

// ==== design/corePkg.sv ====
package corePkg;

    // ========================================
    // Sizes
    // ========================================
    // Word address width, byte address bits 9:2
    localparam int MEM_AW    = 8;
    localparam int MEM_DEPTH = 1 << MEM_AW;

    localparam logic [isaPkg::XLEN-1:0] RESET_PC = '0;

    // ========================================
    // Control
    // ========================================
    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        PASS_B
    } tAluOp;

    typedef struct packed {
        tAluOp op;
        logic  src1Pc;   // Operand 1 is PC, not rs1
        logic  src2Imm;  // Operand 2 is the immediate, not rs2
    } tCtrlAlu;

    typedef struct packed {
        logic [4:0] src1;
        logic [4:0] src2;
        logic [4:0] dst;
        logic       wrEn;
    } tCtrlRf;

    typedef struct packed {
        logic       load;
        logic       store;
        logic       branch;
        logic       jal;
        logic       jalr;
        logic [2:0] cond;
    } tCtrlMem;

    // ========================================
    // Ports and trace
    // ========================================
    typedef struct packed {
        logic                    wrEn;
        logic [MEM_AW-1:0]       addr;
        logic [isaPkg::XLEN-1:0] wrData;
    } tMemPort;

    // Image loading, toData picks the data memory
    typedef struct packed {
        logic                    strobe;
        logic                    toData;
        logic [MEM_AW-1:0]       addr;
        logic [isaPkg::XLEN-1:0] data;
    } tProgLoad;

    typedef struct packed {
        logic                    valid;
        logic [isaPkg::XLEN-1:0] pc;
        logic [4:0]              rd;
        logic [isaPkg::XLEN-1:0] data;
    } tWbTrace;

endpackage

// ==== design/exCoreMem.sv ====
module exCoreMem (
    input  logic                          Clk,
    input  corePkg::tMemPort              portA,
    output logic [isaPkg::XLEN-1:0]       qA,
    input  logic                          loadEn,
    input  logic [corePkg::MEM_AW-1:0]    loadAddr,
    input  logic [isaPkg::XLEN-1:0]       loadData
);

    logic [isaPkg::XLEN-1:0] ram [corePkg::MEM_DEPTH];

    // Port A returns the old word when it writes
    always_ff @(posedge Clk) begin
        qA <= ram[portA.addr];
        if (portA.wrEn) begin
            ram[portA.addr] <= portA.wrData;
        end
        // Load port, only used under reset
        if (loadEn) begin
            ram[loadAddr] <= loadData;
        end
    end

    // Core and loader never race on one word
    noDualWrite: assert property (@(posedge Clk)
        !(portA.wrEn && loadEn && (portA.addr == loadAddr)));

endmodule

// ==== design/exCoreRegFile.sv ====
module exCoreRegFile (
    input  logic                    Clk,
    input  logic                    rstN,
    input  corePkg::tCtrlRf         ctrl,
    input  logic                    wrEn,
    input  logic [4:0]              wrDst,
    input  logic [isaPkg::XLEN-1:0] wrData,
    output logic [isaPkg::XLEN-1:0] rdData1,
    output logic [isaPkg::XLEN-1:0] rdData2
);

    logic [isaPkg::XLEN-1:0] regs [32];

    // Q102 result lands at the clock edge and x0 is never written
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrDst != 5'd0)) begin
            regs[wrDst] <= wrData;
        end
    end

    // Async reads for Q101
    assign rdData1 = regs[ctrl.src1];
    assign rdData2 = regs[ctrl.src2];

    // Upstream drops every write aimed at x0
    noX0Write: assert property (@(posedge Clk) disable iff (!rstN)
        !(wrEn && (wrDst == 5'd0)));

endmodule

// ==== design/exCoreAlu.sv ====
module exCoreAlu (
    input  logic [isaPkg::XLEN-1:0] operand1,
    input  logic [isaPkg::XLEN-1:0] operand2,
    input  corePkg::tAluOp          op,
    output logic [isaPkg::XLEN-1:0] result,
    output logic                    eq,
    output logic                    lt,
    output logic                    ltu
);

    logic [4:0] shamt;

    // Compare flags, also feed branches
    assign eq    = (operand1 == operand2);
    assign lt    = ($signed(operand1) < $signed(operand2));
    assign ltu   = (operand1 < operand2);
    // Shift amount from low five bits
    assign shamt = operand2[4:0];

    always_comb begin
        case (op)
            corePkg::ADD:    result = operand1 + operand2;
            corePkg::SUB:    result = operand1 - operand2;
            corePkg::SLL:    result = operand1 << shamt;
            corePkg::SLT:    result = {{(isaPkg::XLEN-1){1'b0}}, lt};
            corePkg::SLTU:   result = {{(isaPkg::XLEN-1){1'b0}}, ltu};
            corePkg::XOR:    result = operand1 ^ operand2;
            corePkg::SRL:    result = operand1 >> shamt;
            // Arithmetic shift keeps the sign
            corePkg::SRA:    result = $signed(operand1) >>> shamt;
            corePkg::OR:     result = operand1 | operand2;
            corePkg::AND:    result = operand1 & operand2;
            // LUI path
            corePkg::PASS_B: result = operand2;
            default:         result = '0;
        endcase
    end

endmodule

// ==== design/exCoreDecoder.sv ====
module exCoreDecoder (
    input  isaPkg::tInstr           instruction,
    output isaPkg::tOpcode          opcode,
    output corePkg::tCtrlAlu        ctrlAlu,
    output corePkg::tCtrlRf         ctrlRf,
    output corePkg::tCtrlMem        ctrlMem,
    output logic [isaPkg::XLEN-1:0] imm
);

    // Maps funct3 to an ALU op
    // The alt bit selects SUB on register ops and SRA on both
    function automatic corePkg::tAluOp aluOp(
        input logic [2:0] funct3,
        input logic       alt,
        input logic       regOp
    );
        case (funct3)
            isaPkg::F3_ADD:  aluOp = (alt && regOp) ? corePkg::SUB : corePkg::ADD;
            isaPkg::F3_SLL:  aluOp = corePkg::SLL;
            isaPkg::F3_SLT:  aluOp = corePkg::SLT;
            isaPkg::F3_SLTU: aluOp = corePkg::SLTU;
            isaPkg::F3_XOR:  aluOp = corePkg::XOR;
            isaPkg::F3_SR:   aluOp = alt ? corePkg::SRA : corePkg::SRL;
            isaPkg::F3_OR:   aluOp = corePkg::OR;
            default:         aluOp = corePkg::AND;
        endcase
    endfunction

    assign opcode = isaPkg::tOpcode'(instruction.r.opcode);

    always_comb begin
        // Defaults describe a no-op
        ctrlAlu.op      = corePkg::ADD;
        ctrlAlu.src1Pc  = 1'b0;
        ctrlAlu.src2Imm = 1'b1;
        ctrlRf.src1     = instruction.r.rs1;
        ctrlRf.src2     = instruction.r.rs2;
        ctrlRf.dst      = instruction.r.rd;
        ctrlRf.wrEn     = 1'b0;
        ctrlMem         = '0;
        ctrlMem.cond    = instruction.b.funct3;
        imm             = '0;

        case (opcode)
            isaPkg::LUI: begin
                imm         = {instruction.u.imm31_12, 12'b0};
                ctrlAlu.op  = corePkg::PASS_B;
                ctrlRf.wrEn = 1'b1;
            end
            isaPkg::AUIPC: begin
                imm            = {instruction.u.imm31_12, 12'b0};
                ctrlAlu.src1Pc = 1'b1;
                ctrlRf.wrEn    = 1'b1;
            end
            isaPkg::JAL: begin
                imm = {{11{instruction.j.imm20}}, instruction.j.imm20,
                       instruction.j.imm19_12, instruction.j.imm11,
                       instruction.j.imm10_1, 1'b0};
                ctrlAlu.src1Pc = 1'b1;
                ctrlRf.wrEn    = 1'b1;
                ctrlMem.jal    = 1'b1;
            end
            isaPkg::JALR: begin
                imm = {{20{instruction.i.imm11_0[11]}}, instruction.i.imm11_0};
                ctrlRf.wrEn  = 1'b1;
                ctrlMem.jalr = 1'b1;
            end
            // ALU compares rs1 with rs2 while the core adds the offset
            isaPkg::BRANCH: begin
                imm = {{19{instruction.b.imm12}}, instruction.b.imm12,
                       instruction.b.imm11, instruction.b.imm10_5,
                       instruction.b.imm4_1, 1'b0};
                ctrlAlu.op      = corePkg::SUB;
                ctrlAlu.src2Imm = 1'b0;
                ctrlMem.branch  = 1'b1;
            end
            isaPkg::LOAD: begin
                imm = {{20{instruction.i.imm11_0[11]}}, instruction.i.imm11_0};
                ctrlRf.wrEn  = 1'b1;
                ctrlMem.load = 1'b1;
            end
            isaPkg::STORE: begin
                imm = {{20{instruction.s.imm11_5[6]}}, instruction.s.imm11_5,
                       instruction.s.imm4_0};
                ctrlMem.store = 1'b1;
            end
            isaPkg::I_OP: begin
                imm = {{20{instruction.i.imm11_0[11]}}, instruction.i.imm11_0};
                ctrlAlu.op  = aluOp(instruction.i.funct3,
                                    instruction.r.funct7[isaPkg::F7_ALT_BIT], 1'b0);
                ctrlRf.wrEn = 1'b1;
            end
            isaPkg::R_OP: begin
                ctrlAlu.op      = aluOp(instruction.r.funct3,
                                        instruction.r.funct7[isaPkg::F7_ALT_BIT], 1'b1);
                ctrlAlu.src2Imm = 1'b0;
                ctrlRf.wrEn     = 1'b1;
            end
            default: begin
                // Illegal opcodes leave every enable low
            end
        endcase

        // Writes to x0 are dropped here
        if (ctrlRf.dst == 5'd0) begin
            ctrlRf.wrEn = 1'b0;
        end
    end

endmodule

// ==== design/exCore.sv ====
module exCore (
    input  logic              Clk,
    input  logic              rstN,
    input  corePkg::tProgLoad progLoad,
    output corePkg::tWbTrace  wbTrace
);

    // ========================================
    // Pipeline state
    // ========================================
    // Fetch
    logic [isaPkg::XLEN-1:0] pcQ100, nextPcQ100;
    corePkg::tMemPort        iPortQ100;
    // Decode and execute
    logic [isaPkg::XLEN-1:0] pcQ101;
    logic                    validQ101;
    isaPkg::tInstr           instrQ101;
    isaPkg::tOpcode          opcodeQ101;
    corePkg::tCtrlAlu        ctrlAluQ101;
    corePkg::tCtrlRf         ctrlRfQ101;
    corePkg::tCtrlMem        ctrlMemQ101;
    logic [isaPkg::XLEN-1:0] immQ101;
    logic [isaPkg::XLEN-1:0] rdData1Q101, rdData2Q101;
    logic [isaPkg::XLEN-1:0] fwd1Q101, fwd2Q101;
    logic [isaPkg::XLEN-1:0] aluIn1Q101, aluIn2Q101, aluOutQ101;
    logic                    eqQ101, ltQ101, ltuQ101;
    logic                    takenQ101, redirectQ101;
    logic [isaPkg::XLEN-1:0] targetQ101, resultQ101;
    corePkg::tMemPort        dPortQ101;
    // Write back
    logic [isaPkg::XLEN-1:0] pcQ102, resultQ102, memRdDataQ102, wrDataQ102;
    isaPkg::tOpcode          opcodeQ102;
    logic [4:0]              dstQ102;
    logic                    wrEnQ102;

    // ========================================
    // Q100 fetch
    // ========================================
    // Redirect wins over the sequential PC
    assign nextPcQ100 = redirectQ101 ? targetQ101 : pcQ100 + 32'd4;

    assign iPortQ100.wrEn   = 1'b0;
    assign iPortQ100.addr   = pcQ100[corePkg::MEM_AW+1:2];
    assign iPortQ100.wrData = '0;

    exCoreMem i_iMem (
        .Clk      (Clk),
        .portA    (iPortQ100),
        .qA       (instrQ101),
        .loadEn   (progLoad.strobe && !progLoad.toData),
        .loadAddr (progLoad.addr),
        .loadData (progLoad.data)
    );

    // ========================================
    // Q101 decode, execute, memory request
    // ========================================
    exCoreDecoder i_decoder (
        .instruction (instrQ101),
        .opcode      (opcodeQ101),
        .ctrlAlu     (ctrlAluQ101),
        .ctrlRf      (ctrlRfQ101),
        .ctrlMem     (ctrlMemQ101),
        .imm         (immQ101)
    );

    exCoreRegFile i_regFile (
        .Clk     (Clk),
        .rstN    (rstN),
        .ctrl    (ctrlRfQ101),
        .wrEn    (wrEnQ102),
        .wrDst   (dstQ102),
        .wrData  (wrDataQ102),
        .rdData1 (rdData1Q101),
        .rdData2 (rdData2Q101)
    );

    // Q102 bypass, load data included
    assign fwd1Q101 = (wrEnQ102 && (dstQ102 == ctrlRfQ101.src1)) ? wrDataQ102 : rdData1Q101;
    assign fwd2Q101 = (wrEnQ102 && (dstQ102 == ctrlRfQ101.src2)) ? wrDataQ102 : rdData2Q101;

    assign aluIn1Q101 = ctrlAluQ101.src1Pc  ? pcQ101  : fwd1Q101;
    assign aluIn2Q101 = ctrlAluQ101.src2Imm ? immQ101 : fwd2Q101;

    exCoreAlu i_alu (
        .operand1 (aluIn1Q101),
        .operand2 (aluIn2Q101),
        .op       (ctrlAluQ101.op),
        .result   (aluOutQ101),
        .eq       (eqQ101),
        .lt       (ltQ101),
        .ltu      (ltuQ101)
    );

    // Branch condition from the ALU flags
    always_comb begin
        case (ctrlMemQ101.cond)
            isaPkg::F3_BEQ:  takenQ101 = eqQ101;
            isaPkg::F3_BNE:  takenQ101 = !eqQ101;
            isaPkg::F3_BLT:  takenQ101 = ltQ101;
            isaPkg::F3_BGE:  takenQ101 = !ltQ101;
            isaPkg::F3_BLTU: takenQ101 = ltuQ101;
            isaPkg::F3_BGEU: takenQ101 = !ltuQ101;
            default:         takenQ101 = 1'b0;
        endcase
    end

    assign redirectQ101 = validQ101 && (ctrlMemQ101.jal || ctrlMemQ101.jalr ||
                                        (ctrlMemQ101.branch && takenQ101));
    // JALR clears bit 0, the others are PC relative
    assign targetQ101 = ctrlMemQ101.jalr ? {aluOutQ101[isaPkg::XLEN-1:1], 1'b0}
                                         : pcQ101 + immQ101;
    // Jumps link PC plus 4
    assign resultQ101 = (ctrlMemQ101.jal || ctrlMemQ101.jalr) ? pcQ101 + 32'd4 : aluOutQ101;

    // Store is masked when Q101 was flushed
    assign dPortQ101.wrEn   = validQ101 && ctrlMemQ101.store;
    assign dPortQ101.addr   = aluOutQ101[corePkg::MEM_AW+1:2];
    assign dPortQ101.wrData = fwd2Q101;

    exCoreMem i_dMem (
        .Clk      (Clk),
        .portA    (dPortQ101),
        .qA       (memRdDataQ102),
        .loadEn   (progLoad.strobe && progLoad.toData),
        .loadAddr (progLoad.addr),
        .loadData (progLoad.data)
    );

    // ========================================
    // Registers between stages
    // ========================================
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            pcQ100    <= corePkg::RESET_PC;
            validQ101 <= 1'b0;
            wrEnQ102  <= 1'b0;
        end else begin
            pcQ100    <= nextPcQ100;
            // Sequential slot behind a redirect is dropped
            validQ101 <= !redirectQ101;
            wrEnQ102  <= validQ101 && ctrlRfQ101.wrEn;
        end
    end

    always_ff @(posedge Clk) begin
        pcQ101     <= pcQ100;
        pcQ102     <= pcQ101;
        resultQ102 <= resultQ101;
        opcodeQ102 <= opcodeQ101;
        dstQ102    <= ctrlRfQ101.dst;
    end

    // ========================================
    // Q102 write back
    // ========================================
    assign wrDataQ102 = (opcodeQ102 == isaPkg::LOAD) ? memRdDataQ102 : resultQ102;

    assign wbTrace.valid = wrEnQ102;
    assign wbTrace.pc    = pcQ102;
    assign wbTrace.rd    = dstQ102;
    assign wbTrace.data  = wrDataQ102;

endmodule

// ==== tb/exCoreModel.svh ====
`ifndef EX_CORE_MODEL_SVH
`define EX_CORE_MODEL_SVH

// ========================================
// Random program generator
// ========================================
// Instruction classes the generator can emit
localparam int CL_R     = 0;
localparam int CL_I     = 1;
localparam int CL_LUI   = 2;
localparam int CL_AUIPC = 3;
localparam int CL_LW    = 4;
localparam int CL_SW    = 5;
localparam int CL_BR    = 6;
localparam int CL_JAL   = 7;
localparam int CL_JALR  = 8;
localparam int CL_ILL   = 9;

// Class mix per test kind
function automatic int pickClass(input int kind, input logic [31:0] r);
    case (kind)
        KIND_ARITH:  return int'(r[1:0]);
        KIND_DEPEND: return (r[2:0] == 3'd7) ? CL_LW : int'(r[1:0]);
        KIND_MEMORY: return (r[1:0] == 2'd0) ? CL_I : (r[2] ? CL_LW : CL_SW);
        KIND_CTRL:   return r[2] ? CL_BR + int'(r[1:0]) % 3 : int'(r[0]);
        default:     return int'(r[3:0]) % (CL_ILL + 1);
    endcase
endfunction

// Source register biased toward the newest result
function automatic int pickSrc(input int kind, input int lastDst);
    logic [31:0] r;
    r = nextRand();
    if (kind == KIND_DEPEND || r[1:0] == 2'd0) begin
        return lastDst;
    end
    // Some reads of x0
    if (r[4:2] == 3'd0) begin
        return 0;
    end
    return int'(r[12:8]);
endfunction

task automatic genProgram(input int kind);
    logic [31:0] r;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    logic [12:0] offB;
    logic [20:0] offJ;
    int          cls;
    int          skip;
    int          rd;
    int          rs1;
    int          rs2;
    int          lastDst;
    r       = nextRand();
    lastDst = 1 + int'(r[3:0]);
    // First word writes so the trace opens at the reset PC
    prog[0] = {r[31:12], 5'(lastDst), isaPkg::LUI};
    for (int i = 1; i < PROG_LEN - 1; i++) begin
        r    = nextRand();
        cls  = pickClass(kind, r);
        skip = 1 + int'(r[8]);
        // Jumps only forward and never past the parking JAL
        if (cls >= CL_BR && cls <= CL_JALR && i + 1 + skip > PROG_LEN - 1) begin
            cls = CL_I;
        end
        r   = nextRand();
        rd  = (r[2:0] == 3'd0) ? 0 : int'(r[7:3]);
        rs1 = pickSrc(kind, lastDst);
        rs2 = pickSrc(kind, lastDst);
        f3  = r[10:8];
        // Alternate encoding only for ADD/SUB and the right shifts
        f7  = ((f3 == 3'd0 || f3 == 3'd5) && r[11]) ? 7'h20 : 7'h00;
        imm = r[23:12];
        case (cls)
            CL_R: prog[i] = {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), isaPkg::R_OP};
            CL_I: begin
                // Shift immediates carry funct7 and shamt
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    imm = {f7, imm[4:0]};
                end
                prog[i] = {imm, 5'(rs1), f3, 5'(rd), isaPkg::I_OP};
            end
            CL_LUI:   prog[i] = {r[31:12], 5'(rd), isaPkg::LUI};
            CL_AUIPC: prog[i] = {r[31:12], 5'(rd), isaPkg::AUIPC};
            // Word offsets from x0 keep every access inside the RAM
            CL_LW: begin
                imm     = {2'b00, r[31:24], 2'b00};
                prog[i] = {imm, 5'd0, 3'b010, 5'(rd), isaPkg::LOAD};
            end
            CL_SW: begin
                imm     = {2'b00, r[31:24], 2'b00};
                prog[i] = {imm[11:5], 5'(rs2), 5'd0, 3'b010, imm[4:0], isaPkg::STORE};
            end
            CL_BR: begin
                offB = 13'((skip + 1) * 4);
                // Codes 2 and 3 are not branches and fold onto BEQ/BNE
                if (f3[2:1] == 2'b01) begin
                    f3 = {2'b00, f3[0]};
                end
                prog[i] = {offB[12], offB[10:5], 5'(rs2), 5'(rs1), f3,
                           offB[4:1], offB[11], isaPkg::BRANCH};
            end
            CL_JAL: begin
                offJ    = 21'((skip + 1) * 4);
                prog[i] = {offJ[20], offJ[10:1], offJ[11], offJ[19:12], 5'(rd), isaPkg::JAL};
            end
            // Absolute target through x0
            CL_JALR: begin
                imm     = 12'((i + 1 + skip) * 4);
                prog[i] = {imm, 5'd0, 3'b000, 5'(rd), isaPkg::JALR};
            end
            default: prog[i] = {r[31:7], 7'b0001011};
        endcase
        if (cls inside {CL_R, CL_I, CL_LUI, CL_AUIPC, CL_LW, CL_JAL, CL_JALR} && rd != 0) begin
            lastDst = rd;
        end
    end
    // Park on a JAL to itself with no more writes
    prog[PROG_LEN-1] = {20'd0, 5'd0, isaPkg::JAL};
endtask

// ========================================
// Instruction-level reference model
// ========================================
function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                       input logic [31:0] a, input logic [31:0] b);
    logic signed [31:0] sa;
    sa = a;
    case (f3)
        3'd0: return alt ? a - b : a + b;
        3'd1: return a << b[4:0];
        3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3: return (a < b) ? 32'd1 : 32'd0;
        3'd4: return a ^ b;
        3'd5: begin
            if (alt) begin
                return sa >>> b[4:0];
            end
            return a >> b[4:0];
        end
        3'd6: return a | b;
        default: return a & b;
    endcase
endfunction

// Runs prog on a private state and fills the expected trace
task automatic runModel();
    logic [31:0] x [32];
    logic [31:0] dmem [corePkg::MEM_DEPTH];
    logic [31:0] pc;
    logic [31:0] nextPc;
    logic [31:0] instr;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] val;
    logic [31:0] ea;
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immB;
    logic [31:0] immU;
    logic [31:0] immJ;
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic        wr;
    logic        taken;
    int          steps;
    for (int k = 0; k < 32; k++) begin
        x[k] = '0;
    end
    for (int k = 0; k < corePkg::MEM_DEPTH; k++) begin
        dmem[k] = dataInit[k];
    end
    expPc.delete();
    expRd.delete();
    expData.delete();
    pc    = corePkg::RESET_PC;
    steps = 0;
    while (pc != (PROG_LEN - 1) * 4 && steps < 4 * PROG_LEN) begin
        instr  = prog[pc[9:2]];
        rd     = instr[11:7];
        f3     = instr[14:12];
        a      = x[instr[19:15]];
        b      = x[instr[24:20]];
        // Immediates per ISA format
        immI   = {{20{instr[31]}}, instr[31:20]};
        immS   = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        immB   = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        immU   = {instr[31:12], 12'b0};
        immJ   = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
        nextPc = pc + 32'd4;
        wr     = 1'b1;
        val    = '0;
        case (instr[6:0])
            isaPkg::LUI:   val = immU;
            isaPkg::AUIPC: val = pc + immU;
            isaPkg::JAL: begin
                val    = pc + 32'd4;
                nextPc = pc + immJ;
            end
            isaPkg::JALR: begin
                val    = pc + 32'd4;
                nextPc = (a + immI) & ~32'd1;
            end
            isaPkg::BRANCH: begin
                wr = 1'b0;
                case (f3)
                    3'b000:  taken = (a == b);
                    3'b001:  taken = (a != b);
                    3'b100:  taken = ($signed(a) < $signed(b));
                    3'b101:  taken = ($signed(a) >= $signed(b));
                    3'b110:  taken = (a < b);
                    3'b111:  taken = (a >= b);
                    default: taken = 1'b0;
                endcase
                if (taken) begin
                    nextPc = pc + immB;
                end
            end
            isaPkg::LOAD: begin
                ea  = a + immI;
                val = dmem[ea[9:2]];
            end
            isaPkg::STORE: begin
                wr           = 1'b0;
                ea           = a + immS;
                dmem[ea[9:2]] = b;
            end
            // Only the right shifts see the alternate bit here
            isaPkg::I_OP: val = aluRef(f3, (f3 == 3'd5) && instr[30], a, immI);
            isaPkg::R_OP: val = aluRef(f3, instr[30], a, b);
            default: wr = 1'b0;
        endcase
        if (wr && rd != 5'd0) begin
            x[rd] = val;
            expPc.push_back(pc);
            expRd.push_back(rd);
            expData.push_back(val);
        end
        pc = nextPc;
        steps++;
    end
endtask

`endif

// ==== tb/exCoreTb.sv ====
module exCoreTb;

    // ========================================
    // Test setup
    // ========================================
    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 4;
    localparam int PROG_LEN     = 64;
    localparam int NUM_TESTS    = 5;
    // Quiet cycles after the last expected write
    localparam int DRAIN_CYCLES = 8;
    // Reset, both images, two cycles per instruction and some slack
    localparam int TEST_CYCLES  = RESET_CYCLES + PROG_LEN + corePkg::MEM_DEPTH
                                  + 2 * PROG_LEN + 20 + DRAIN_CYCLES;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * TEST_CYCLES;

    localparam int KIND_ARITH  = 0;
    localparam int KIND_DEPEND = 1;
    localparam int KIND_MEMORY = 2;
    localparam int KIND_CTRL   = 3;
    localparam int KIND_MIXED  = 4;

    logic              Clk;
    logic              rstN;
    corePkg::tProgLoad progLoad;
    corePkg::tWbTrace  wbTrace;

    logic [31:0] rngState;
    logic [31:0] prog [corePkg::MEM_DEPTH];
    logic [31:0] dataInit [corePkg::MEM_DEPTH];
    // Expected write-back list from the model
    logic [31:0] expPc [$];
    logic [4:0]  expRd [$];
    logic [31:0] expData [$];
    int          gotCount;
    int          errorCount;
    int          checkCount;
    int          badTests;

    // xorshift32 stream
    function automatic logic [31:0] xorshift(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] nextRand();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    `include "exCoreModel.svh"

    exCore i_exCore (
        .Clk      (Clk),
        .rstN     (rstN),
        .progLoad (progLoad),
        .wbTrace  (wbTrace)
    );

    initial begin
        Clk = 1'b0;
        forever #(CLK_PERIOD / 2) Clk = ~Clk;
    end

    // ========================================
    // Checking
    // ========================================
    task automatic compare(input string name, input logic [31:0] expVal,
                           input logic [31:0] actVal);
        checkCount++;
        if (expVal !== actVal) begin
            errorCount++;
            $display("Mismatch at time %0t: %s expected %h, got %h", $time, name, expVal, actVal);
        end
    endtask

    // Outputs settle after the rising edge and are sampled on the falling one
    always @(negedge Clk) begin
        if (!rstN) begin
            compare("wbTrace.valid", 32'd0, {31'd0, wbTrace.valid});
        end else if (wbTrace.valid) begin
            if (gotCount < expPc.size()) begin
                compare("wbTrace.pc", expPc[gotCount], wbTrace.pc);
                compare("wbTrace.rd", {27'd0, expRd[gotCount]}, {27'd0, wbTrace.rd});
                compare("wbTrace.data", expData[gotCount], wbTrace.data);
                gotCount++;
            end else begin
                errorCount++;
                $display("Unexpected write-back at time %0t: pc %h wrote x%0d with %h",
                         $time, wbTrace.pc, wbTrace.rd, wbTrace.data);
            end
        end
    end

    // ========================================
    // Stimulus
    // ========================================
    task automatic loadWord(input logic toData, input int addr, input logic [31:0] data);
        @(posedge Clk);
        progLoad.strobe <= 1'b1;
        progLoad.toData <= toData;
        progLoad.addr   <= addr[corePkg::MEM_AW-1:0];
        progLoad.data   <= data;
    endtask

    task automatic runTest(input int kind, input string name);
        int startErrors;
        startErrors = errorCount;
        @(posedge Clk);
        rstN     <= 1'b0;
        gotCount  = 0;
        // New program, data image and expected trace
        genProgram(kind);
        for (int k = 0; k < corePkg::MEM_DEPTH; k++) begin
            dataInit[k] = nextRand();
        end
        runModel();
        repeat (RESET_CYCLES) @(posedge Clk);
        // Both images go in while the core sits in reset
        for (int k = 0; k < PROG_LEN; k++) begin
            loadWord(1'b0, k, prog[k]);
        end
        for (int k = 0; k < corePkg::MEM_DEPTH; k++) begin
            loadWord(1'b1, k, dataInit[k]);
        end
        @(posedge Clk);
        progLoad <= '0;
        rstN     <= 1'b1;
        while (gotCount < expPc.size()) begin
            @(negedge Clk);
        end
        repeat (DRAIN_CYCLES) @(negedge Clk);
        if (errorCount == startErrors) begin
            $display("%-8s PASS  %0d writes", name, expPc.size());
        end else begin
            badTests++;
            $display("%-8s FAIL  %0d of %0d writes seen, %0d errors", name, gotCount,
                     expPc.size(), errorCount - startErrors);
        end
    endtask

    initial begin
        rstN       = 1'b0;
        progLoad   = '0;
        rngState   = 32'h5c58;
        gotCount   = 0;
        errorCount = 0;
        checkCount = 0;
        badTests   = 0;
        runTest(KIND_ARITH, "arith");
        runTest(KIND_DEPEND, "depend");
        runTest(KIND_MEMORY, "memory");
        runTest(KIND_CTRL, "control");
        runTest(KIND_MIXED, "mixed");
        $display("Summary: %0d tests, %0d bad, %0d checks, %0d errors",
                 NUM_TESTS, badTests, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge Clk);
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("test failed");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+tb
design/isaPkg.sv
design/corePkg.sv
design/exCoreMem.sv
design/exCoreRegFile.sv
design/exCoreAlu.sv
design/exCoreDecoder.sv
design/exCore.sv
tb/exCoreTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= exCoreTb
RTL_TOP   ?= exCore
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing
FAIL_MSG  ?= test failed

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	@./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
